// File: dv/audio_golden.txt
# W addr data | R addr data | K rate pin | M addr word | A dma addr | B busy | D test id
# T a0 a1: fetches of a0/a1, tick, clamped sum of both words out (ffffffff is silence)
R 0 00000011
R 1 00000000
W 0 00000022
R 0 00000022
K 00000022
R 9 00000000
D 1
W 1 00001000
W 2 00000003
T 00001000 ffffffff
T 00001004 ffffffff
B 00000001
T 00001008 ffffffff
T ffffffff ffffffff
B 00000000
D 2
M 00002000 90007000
M 00003000 a0006000
W 1 00002000
W 3 00003000
W 2 00000003
W 4 00000003
T 00002000 00003000
T 00002004 00003004
T 00002008 00003008
B 00000000
D 3
W 1 00004000
W 2 00000002
W 1 00005000
W 2 80000001
T 00004000 ffffffff
T 00004004 ffffffff
T 00005000 ffffffff
B 00000000
D 4
W 1 00006000
W 2 00000003
A 00006000
W 1 00007000
W 2 00000002
T 00007000 ffffffff
T 00007004 ffffffff
B 00000000
D 5

// File: project.f
verilog/audio_pkg.sv
verilog/audio_dma_if.sv
verilog/audio_regs.sv
verilog/audio_channel.sv
verilog/audio_dma_arbiter.sv
verilog/audio_mixer.sv
verilog/audio_controller.sv
dv/tb_audio_controller.sv

// File: Bender.yml
package:
  name: audio_controller

sources:
  - verilog/audio_pkg.sv
  - verilog/audio_dma_if.sv
  - verilog/audio_regs.sv
  - verilog/audio_channel.sv
  - verilog/audio_dma_arbiter.sv
  - verilog/audio_mixer.sv
  - verilog/audio_controller.sv
  - target: test
    files:
      - dv/tb_audio_controller.sv

// File: dv/tb_audio_controller.sv
`timescale 1ns/100ps

module tb_audio_controller;

	localparam int WAIT_LIMIT = 100;
	localparam logic [31:0] SILENT = 32'hffffffff;

	logic        i_clock;
	logic        i_reset;
	logic        i_request;
	logic        i_rw;
	logic [3:0]  i_address;
	logic [31:0] i_wdata;
	logic [31:0] o_rdata;
	logic        o_ready;
	logic        o_dma_request;
	logic [31:0] o_dma_address;
	logic        i_dma_ready;
	logic [31:0] i_dma_rdata;
	logic        i_sample_tick;
	logic [31:0] o_sample_rate;
	logic [15:0] o_sample_left;
	logic [15:0] o_sample_right;

	logic [31:0] preset_address [$];
	logic [31:0] preset_data [$];
	logic [31:0] fetched [$];
	logic [31:0] rng_state;
	int          dma_delay;
	int          errors;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;
	bit          timed_out;

	audio_controller u_audio_controller (.*);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Memory image hashes the whole address unless the golden file presets it
	function automatic logic [31:0] mem_word(input logic [31:0] address);
		for (int i = 0; i < preset_address.size(); i++) begin
			if (preset_address[i] == address) begin
				return preset_data[i];
			end
		end
		return xorshift(xorshift(32'd45 ^ address));
	endfunction

	function automatic audio_pkg::sample_t clamp_add(input audio_pkg::sample_t a,
			input audio_pkg::sample_t b);
		int sum;
		sum = int'(a) + int'(b);
		if (sum > audio_pkg::SAMPLE_MAX) begin
			return audio_pkg::SAMPLE_MAX;
		end else if (sum < audio_pkg::SAMPLE_MIN) begin
			return audio_pkg::SAMPLE_MIN;
		end
		return sum[15:0];
	endfunction

	function automatic audio_pkg::stereo_t mixed_word(input logic [31:0] a0, input logic [31:0] a1);
		audio_pkg::stereo_t w0;
		audio_pkg::stereo_t w1;
		audio_pkg::stereo_t mix;
		w0 = (a0 == SILENT) ? '0 : mem_word(a0);
		w1 = (a1 == SILENT) ? '0 : mem_word(a1);
		mix.left = clamp_add(w0.left, w1.left);
		mix.right = clamp_add(w0.right, w1.right);
		return mix;
	endfunction

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic note_timeout(input string what);
		$display("timeout: %s", what);
		timed_out = 1'b1;
		count_error();
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL %s got %h expected %h", name, got, expected);
			count_error();
		end
	endtask

	task automatic check_stereo(input audio_pkg::stereo_t got, input audio_pkg::stereo_t expected);
		if (got !== expected) begin
			$display("FAIL o_sample_left/o_sample_right got %h/%h expected %h/%h",
				got.left, got.right, expected.left, expected.right);
			count_error();
		end
	endtask

	task automatic check_address(input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL o_dma_address got %h expected %h", got, expected);
			count_error();
		end
	endtask

	// Level handshake, request held until ready and ready awaited low again
	task automatic cpu_access(input logic rw, input logic [3:0] address, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		@(negedge i_clock);
		i_request = 1'b1;
		i_rw = rw;
		i_address = address;
		i_wdata = wdata;
		n = 0;
		while (!o_ready && n < WAIT_LIMIT) begin
			@(negedge i_clock);
			n++;
		end
		if (!o_ready) begin
			note_timeout("CPU ready never rose");
		end
		rdata = o_rdata;
		i_request = 1'b0;
		n = 0;
		while (o_ready && n < WAIT_LIMIT) begin
			@(negedge i_clock);
			n++;
		end
		if (o_ready) begin
			note_timeout("CPU ready never fell");
		end
	endtask

	task automatic expect_fetch(input logic [31:0] address);
		int n;
		n = 0;
		while (fetched.size() == 0 && n < WAIT_LIMIT) begin
			@(negedge i_clock);
			n++;
		end
		if (fetched.size() == 0) begin
			note_timeout($sformatf("no DMA read of address %h", address));
		end else begin
			check_address(fetched.pop_front(), address);
		end
	endtask

	task automatic play(input logic [31:0] a0, input logic [31:0] a1);
		int n;
		logic [31:0] want [$];
		audio_pkg::stereo_t got;
		if (a0 != SILENT) want.push_back(a0);
		if (a1 != SILENT) want.push_back(a1);
		n = 0;
		while (fetched.size() < want.size() && n < WAIT_LIMIT) begin
			@(negedge i_clock);
			n++;
		end
		if (fetched.size() < want.size()) begin
			note_timeout("DMA words missing before the sample tick");
		end else begin
			// The two channels may be served in either order
			if (want.size() == 2 && fetched[0] == a1) begin
				want[0] = a1;
				want[1] = a0;
			end
			for (int i = 0; i < want.size(); i++) begin
				check_address(fetched.pop_front(), want[i]);
			end
			@(negedge i_clock);
			i_sample_tick = 1'b1;
			@(negedge i_clock);
			i_sample_tick = 1'b0;
			// Channel register, then mixer register
			@(negedge i_clock);
			got = {o_sample_right, o_sample_left};
			check_stereo(got, mixed_word(a0, a1));
		end
	endtask

	task automatic expect_busy(input logic [31:0] expected);
		int n;
		logic [31:0] status;
		cpu_access(1'b0, audio_pkg::REG_STATUS, '0, status);
		n = 0;
		while (status !== expected && n < WAIT_LIMIT && !timed_out) begin
			cpu_access(1'b0, audio_pkg::REG_STATUS, '0, status);
			n++;
		end
		if (status !== expected && !timed_out) begin
			note_timeout($sformatf("busy bits stuck at %h instead of %h", status, expected));
		end
	endtask

	// DMA memory answers after zero to three cycles
	always @(negedge i_clock) begin
		if (i_dma_ready) begin
			i_dma_ready = 1'b0;
		end else if (!i_reset && o_dma_request) begin
			if (dma_delay == 0) begin
				i_dma_ready = 1'b1;
				i_dma_rdata = mem_word(o_dma_address);
				fetched.push_back(o_dma_address);
				rng_state = xorshift(rng_state);
				dma_delay = rng_state[1:0];
			end else begin
				dma_delay--;
			end
		end
	end

	initial begin
		int fd;
		int count;
		logic [7:0] cmd;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] rdata;
		logic [8*120-1:0] line;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_dma_ready = 1'b0;
		i_dma_rdata = '0;
		i_sample_tick = 1'b0;
		rng_state = 32'd45;
		dma_delay = 0;
		errors = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		repeat (4) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		fd = $fopen("dv/audio_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file dv/audio_golden.txt");
			errors++;
		end else begin
			while (!timed_out && $fscanf(fd, "%s", cmd) == 1) begin
				case (cmd)
					"#": count = $fgets(line, fd);
					"W": begin
						count = $fscanf(fd, "%h %h", arg_a, arg_b);
						cpu_access(1'b1, arg_a[3:0], arg_b, rdata);
					end
					"R": begin
						count = $fscanf(fd, "%h %h", arg_a, arg_b);
						cpu_access(1'b0, arg_a[3:0], '0, rdata);
						check_word("o_rdata", rdata, arg_b);
					end
					"K": begin
						count = $fscanf(fd, "%h", arg_a);
						check_word("o_sample_rate", o_sample_rate, arg_a);
					end
					"M": begin
						count = $fscanf(fd, "%h %h", arg_a, arg_b);
						preset_address.push_back(arg_a);
						preset_data.push_back(arg_b);
					end
					"A": begin
						count = $fscanf(fd, "%h", arg_a);
						expect_fetch(arg_a);
					end
					"T": begin
						count = $fscanf(fd, "%h %h", arg_a, arg_b);
						play(arg_a, arg_b);
					end
					"B": begin
						count = $fscanf(fd, "%h", arg_a);
						expect_busy(arg_a);
					end
					"D": begin
						count = $fscanf(fd, "%h", arg_a);
						while (fetched.size() > 0) begin
							$display("unexpected DMA read of address %h", fetched.pop_front());
							count_error();
						end
						if (test_errors == 0) begin
							tests_passed++;
							$display("test %0d: pass", arg_a);
						end else begin
							tests_failed++;
							$display("test %0d: fail with %0d errors", arg_a, test_errors);
						end
						test_errors = 0;
					end
					default: begin
						$display("unknown command %s in the golden file", cmd);
						count_error();
					end
				endcase
			end
			$fclose(fd);
		end

		if (timed_out) begin
			tests_failed++;
		end
		$display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_passed > 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/audio_controller.sv
`timescale 1ns/100ps

module audio_controller (
	input  logic        i_clock,
	input  logic        i_reset,

	input  logic        i_request,
	input  logic        i_rw,
	input  logic [3:0]  i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ready,

	output logic        o_dma_request,
	output logic [31:0] o_dma_address,
	input  logic        i_dma_ready,
	input  logic [31:0] i_dma_rdata,

	input  logic        i_sample_tick,
	output logic [31:0] o_sample_rate,
	output logic [15:0] o_sample_left,
	output logic [15:0] o_sample_right
);

	logic [audio_pkg::NUM_CHANNELS-1:0] busy;
	logic [audio_pkg::NUM_CHANNELS-1:0] setup_strobe;
	audio_pkg::descriptor_t             descriptor [audio_pkg::NUM_CHANNELS];
	audio_pkg::stereo_t                 channel_sample [audio_pkg::NUM_CHANNELS];
	audio_pkg::stereo_t                 mix_sample;

	audio_dma_if dma_0 ();
	audio_dma_if dma_1 ();

	audio_regs u_audio_regs (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_request      (i_request),
		.i_rw           (i_rw),
		.i_address      (audio_pkg::reg_addr_e'(i_address)),
		.i_wdata        (i_wdata),
		.i_busy         (busy),
		.o_rdata        (o_rdata),
		.o_ready        (o_ready),
		.o_sample_rate  (o_sample_rate),
		.o_setup_strobe (setup_strobe),
		.o_descriptor   (descriptor)
	);

	audio_channel u_channel_0 (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_setup_strobe (setup_strobe[0]),
		.i_descriptor   (descriptor[0]),
		.i_sample_tick  (i_sample_tick),
		.dma            (dma_0.channel),
		.o_busy         (busy[0]),
		.o_sample       (channel_sample[0])
	);

	audio_channel u_channel_1 (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_setup_strobe (setup_strobe[1]),
		.i_descriptor   (descriptor[1]),
		.i_sample_tick  (i_sample_tick),
		.dma            (dma_1.channel),
		.o_busy         (busy[1]),
		.o_sample       (channel_sample[1])
	);

	audio_dma_arbiter u_audio_dma_arbiter (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_dma_ready   (i_dma_ready),
		.i_dma_rdata   (i_dma_rdata),
		.ch0           (dma_0.arbiter),
		.ch1           (dma_1.arbiter),
		.o_dma_request (o_dma_request),
		.o_dma_address (o_dma_address)
	);

	audio_mixer u_audio_mixer (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_sample_a (channel_sample[0]),
		.i_sample_b (channel_sample[1]),
		.o_sample   (mix_sample)
	);

	assign o_sample_left = mix_sample.left;
	assign o_sample_right = mix_sample.right;

endmodule

// File: verilog/audio_mixer.sv
`timescale 1ns/100ps

module audio_mixer (
	input  logic               i_clock,
	input  logic               i_reset,
	input  audio_pkg::stereo_t i_sample_a,
	input  audio_pkg::stereo_t i_sample_b,
	output audio_pkg::stereo_t o_sample
);

	logic signed [16:0] sum_left;
	logic signed [16:0] sum_right;

	function automatic audio_pkg::sample_t saturate(input logic signed [16:0] sum);
		if (sum > audio_pkg::SAMPLE_MAX) begin
			return audio_pkg::SAMPLE_MAX;
		end else if (sum < audio_pkg::SAMPLE_MIN) begin
			return audio_pkg::SAMPLE_MIN;
		end
		return sum[15:0];
	endfunction

	// One extra bit holds any sum of two samples
	assign sum_left = $signed({i_sample_a.left[15], i_sample_a.left})
		+ $signed({i_sample_b.left[15], i_sample_b.left});
	assign sum_right = $signed({i_sample_a.right[15], i_sample_a.right})
		+ $signed({i_sample_b.right[15], i_sample_b.right});

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_sample <= '0;
		end else begin
			o_sample.left <= saturate(sum_left);
			o_sample.right <= saturate(sum_right);
		end
	end

endmodule

// File: verilog/audio_dma_arbiter.sv
`timescale 1ns/100ps

module audio_dma_arbiter (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_dma_ready,
	input  logic [31:0] i_dma_rdata,
	audio_dma_if.arbiter ch0,
	audio_dma_if.arbiter ch1,
	output logic        o_dma_request,
	output logic [31:0] o_dma_address
);

	logic [audio_pkg::NUM_CHANNELS-1:0]         request;
	logic [audio_pkg::NUM_CHANNELS-1:0]         grant_ready;
	logic [31:0]                                address [audio_pkg::NUM_CHANNELS];
	logic [$clog2(audio_pkg::NUM_CHANNELS)-1:0] pointer;
	logic [$clog2(audio_pkg::NUM_CHANNELS)-1:0] next_pointer;

	assign request = {ch1.request, ch0.request};
	assign address[0] = ch0.address;
	assign address[1] = ch1.address;

	assign next_pointer = (pointer == audio_pkg::NUM_CHANNELS - 1) ? '0 : pointer + 1'b1;

	// Ready goes only to the channel under the pointer
	always_comb begin
		grant_ready = '0;
		grant_ready[pointer] = o_dma_request && i_dma_ready;
	end

	assign ch0.ready = grant_ready[0];
	assign ch1.ready = grant_ready[1];
	assign ch0.rdata = i_dma_rdata;
	assign ch1.rdata = i_dma_rdata;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_dma_request <= 1'b0;
			pointer <= '0;
		end else if (o_dma_request) begin
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
				pointer <= next_pointer;
			end
		end else if (request[pointer]) begin
			o_dma_request <= 1'b1;
			o_dma_address <= address[pointer];
		end else begin
			pointer <= next_pointer;
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		!(ch0.ready && ch1.ready) && (!ch0.ready || ch0.request) && (!ch1.ready || ch1.request));

endmodule

// File: verilog/audio_channel.sv
`timescale 1ns/100ps

module audio_channel (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_setup_strobe,
	input  audio_pkg::descriptor_t i_descriptor,
	input  logic                   i_sample_tick,
	audio_dma_if.channel           dma,
	output logic                   o_busy,
	output audio_pkg::stereo_t     o_sample
);

	logic [31:0]                   act_address;
	logic [audio_pkg::COUNT_W-1:0] act_count;
	audio_pkg::descriptor_t        pending;
	logic                          pending_valid;
	logic                          request_q;
	logic [31:0]                   fetch_address;
	logic                          discard;
	audio_pkg::stereo_t            buffer;
	logic                          buffer_full;
	logic                          active;
	logic                          replace;

	// Pending entry counts as active in the cycle it is promoted
	assign active = (act_count != '0) || pending_valid;
	assign replace = i_setup_strobe && !i_descriptor.append;

	assign dma.request = request_q;
	assign dma.address = fetch_address;
	assign o_busy = (act_count != '0) || pending_valid || buffer_full;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			act_count <= '0;
			pending_valid <= 1'b0;
			request_q <= 1'b0;
			discard <= 1'b0;
			buffer_full <= 1'b0;
			o_sample <= '0;
		end else begin
			// Underrun plays silence
			if (i_sample_tick) begin
				o_sample <= buffer_full ? buffer : '0;
				buffer_full <= 1'b0;
			end

			if (dma.ready) begin
				request_q <= 1'b0;
				discard <= 1'b0;
			end

			if (dma.ready && !discard && !replace) begin
				buffer <= dma.rdata;
				buffer_full <= 1'b1;
				act_address <= act_address + 32'd4;
				act_count <= act_count - 1'b1;
			end else if (!request_q && !i_setup_strobe && act_count != '0 && !buffer_full) begin
				request_q <= 1'b1;
				fetch_address <= act_address;
			end

			if (act_count == '0 && pending_valid) begin
				act_address <= pending.address;
				act_count <= pending.count;
				pending_valid <= 1'b0;
			end

			if (i_setup_strobe) begin
				if (replace || !active) begin
					act_address <= i_descriptor.address;
					act_count <= i_descriptor.count;
					pending_valid <= 1'b0;
				end else begin
					pending <= i_descriptor;
					pending_valid <= 1'b1;
				end
				if (replace) begin
					buffer_full <= 1'b0;
					// Word still in flight belongs to the old descriptor
					discard <= request_q && !dma.ready;
				end
			end
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		dma.request && !dma.ready |=> dma.request && $stable(dma.address));

endmodule

// File: verilog/audio_regs.sv
`timescale 1ns/100ps

module audio_regs (
	input  logic                                 i_clock,
	input  logic                                 i_reset,
	input  logic                                 i_request,
	input  logic                                 i_rw,
	input  audio_pkg::reg_addr_e                 i_address,
	input  logic [31:0]                          i_wdata,
	input  logic [audio_pkg::NUM_CHANNELS-1:0]   i_busy,
	output logic [31:0]                          o_rdata,
	output logic                                 o_ready,
	output logic [31:0]                          o_sample_rate,
	output logic [audio_pkg::NUM_CHANNELS-1:0]   o_setup_strobe,
	output audio_pkg::descriptor_t               o_descriptor [audio_pkg::NUM_CHANNELS]
);

	logic [31:0] status;

	assign status = {{(32 - audio_pkg::NUM_CHANNELS){1'b0}}, i_busy};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_setup_strobe <= '0;
			o_sample_rate <= audio_pkg::RATE_RESET;
		end else begin
			o_setup_strobe <= '0;
			if (i_request && !o_ready) begin
				o_ready <= 1'b1;
				o_rdata <= '0;
				if (!i_rw) begin
					case (i_address)
						audio_pkg::REG_RATE:   o_rdata <= o_sample_rate;
						audio_pkg::REG_STATUS: o_rdata <= status;
						default:               o_rdata <= '0;
					endcase
				end else begin
					case (i_address)
						audio_pkg::REG_RATE: o_sample_rate <= i_wdata;
						audio_pkg::REG_CH0_ADDR: o_descriptor[0].address <= i_wdata;
						audio_pkg::REG_CH0_COUNT: begin
							o_descriptor[0].count <= i_wdata[audio_pkg::COUNT_W-1:0];
							o_descriptor[0].append <= i_wdata[31];
							o_setup_strobe[0] <= 1'b1;
						end
						audio_pkg::REG_CH1_ADDR: o_descriptor[1].address <= i_wdata;
						audio_pkg::REG_CH1_COUNT: begin
							o_descriptor[1].count <= i_wdata[audio_pkg::COUNT_W-1:0];
							o_descriptor[1].append <= i_wdata[31];
							o_setup_strobe[1] <= 1'b1;
						end
						default: ;
					endcase
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	// A new access needs ready to fall first, so strobes are always isolated
	assert property (@(posedge i_clock) disable iff (i_reset)
		|o_setup_strobe |=> o_setup_strobe == '0);

endmodule

// File: verilog/audio_dma_if.sv
`timescale 1ns/100ps

interface audio_dma_if;

	logic        request;
	logic [31:0] address;
	logic        ready;
	logic [31:0] rdata;

	modport channel (
		output request,
		output address,
		input  ready,
		input  rdata
	);

	modport arbiter (
		input  request,
		input  address,
		output ready,
		output rdata
	);

endinterface

// File: verilog/audio_pkg.sv
package audio_pkg;

	localparam int NUM_CHANNELS = 2;
	localparam int COUNT_W = 24;

	// 100 MHz / (256 * 22050)
	localparam logic [31:0] RATE_RESET = 32'd17;

	typedef logic signed [15:0] sample_t;

	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = -16'sh8000;

	// Left in the low half of a DMA word, right in the high half
	typedef struct packed {
		sample_t right;
		sample_t left;
	} stereo_t;

	typedef struct packed {
		logic [31:0]        address;
		logic [COUNT_W-1:0] count;
		logic               append;
	} descriptor_t;

	typedef enum logic [3:0] {
		REG_RATE      = 4'd0,
		REG_CH0_ADDR  = 4'd1,
		REG_CH0_COUNT = 4'd2,
		REG_CH1_ADDR  = 4'd3,
		REG_CH1_COUNT = 4'd4
	} reg_addr_e;

	// Busy bits share the channel 0 address slot on reads
	localparam reg_addr_e REG_STATUS = REG_CH0_ADDR;

endpackage
